// ==== run.sh ====
#!/bin/sh
# builds the simulation with Verilator and runs it, the exit status carries the result
cd "$(dirname "$0")" &&
  verilator --binary --timing --timescale 1ns/1ns -f vlog.f \
    --top-module lsu_tb -o lsu_sim &&
  ./obj_dir/lsu_sim ||
  exit 1

// ==== src/accessor.sv ====
`timescale 1ns/1ns

module accessor #(
  parameter int ram_words = 256
) (
  input  logic                         clk,
  input  logic                         reset,
  // request from the execute stage
  input  logic                         req_valid,
  output logic                         req_ready,
  input  lsu_pkg::access_req_t         req,
  // result toward load_align
  output logic                         result_valid,
  input  logic                         result_ready,
  output lsu_pkg::access_result_t      result,
  // memory side
  output logic                         mem_valid,
  input  logic                         mem_ready,
  output logic [$clog2(ram_words)-1:0] mem_addr,
  output logic [3:0]                   mem_wstrb,
  output logic [31:0]                  mem_wdata,
  input  logic [31:0]                  mem_rdata
);

  localparam int addr_w = $clog2(ram_words);

  typedef enum logic [1:0] {
    st_idle,
    st_wait_mem,
    st_full
  } state_t;

  state_t      state;
  logic        accept;
  logic [3:0]  wstrb_next;
  logic [31:0] wdata_next;

  // a new request may enter while the result slot drains
  assign req_ready    = (state == st_idle) || ((state == st_full) && result_ready);
  assign accept       = req_valid && req_ready;
  assign result_valid = (state == st_full);

  // loads keep all strobes low
  always_comb begin
    wstrb_next = 4'b0000;
    wdata_next = req.store_data;
    if (req.is_store) begin
      case (req.size)
        lsu_pkg::size_word: begin
          wstrb_next = 4'b1111;
        end
        lsu_pkg::size_half: begin
          wstrb_next = req.addr[1] ? 4'b1100 : 4'b0011;
          wdata_next = {2{req.store_data[15:0]}};
        end
        default: begin
          wstrb_next = 4'b0001 << req.addr[1:0];
          wdata_next = {4{req.store_data[7:0]}};
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= st_idle;
      mem_valid <= 1'b0;
    end else begin
      case (state)
        st_wait_mem: begin
          // request stays up until the RAM answers
          if (mem_ready) begin
            mem_valid <= 1'b0;
            state     <= st_full;
          end
        end
        default: begin
          if (accept) begin
            if (req.trap) begin
              state <= st_full;
            end else begin
              mem_valid <= 1'b1;
              state     <= st_wait_mem;
            end
          end else if ((state == st_full) && result_ready) begin
            state <= st_idle;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      mem_addr           <= req.addr[addr_w+1:2];
      mem_wstrb          <= wstrb_next;
      mem_wdata          <= wdata_next;
      result.is_load     <= req.is_load;
      result.is_unsigned <= req.is_unsigned;
      result.size        <= req.size;
      result.rd          <= req.rd;
      result.byte_offset <= req.addr[1:0];
      result.raw_data    <= '0;
      result.trap        <= req.trap;
    end else if ((state == st_wait_mem) && mem_ready) begin
      result.raw_data <= mem_rdata;
    end
  end

endmodule

// ==== src/data_ram.sv ====
`timescale 1ns/1ns

module data_ram #(
  parameter int ram_words = 256
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         mem_valid,
  output logic                         mem_ready,
  input  logic [$clog2(ram_words)-1:0] mem_addr,
  input  logic [3:0]                   mem_wstrb,
  input  logic [31:0]                  mem_wdata,
  output logic [31:0]                  mem_rdata
);

  logic [31:0] words [ram_words];
  logic        take;

  initial begin
    for (int i = 0; i < ram_words; i++) begin
      words[i] = 32'd0;
    end
  end

  // a request is served once, ready drops right after the pulse
  assign take = mem_valid && !mem_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      mem_ready <= 1'b0;
    end else begin
      mem_ready <= take;
    end
  end

  // read returns the word as it was before the write
  always_ff @(posedge clk) begin
    if (take) begin
      mem_rdata <= words[mem_addr];
      for (int lane = 0; lane < 4; lane++) begin
        if (mem_wstrb[lane]) begin
          words[mem_addr][lane*8 +: 8] <= mem_wdata[lane*8 +: 8];
        end
      end
    end
  end

endmodule

// ==== src/load_align.sv ====
`timescale 1ns/1ns

module load_align (
  input  lsu_pkg::access_result_t in,
  output lsu_pkg::writeback_t     out
);

  logic [7:0]  sel_byte;
  logic [15:0] sel_half;
  logic [31:0] load_value;

  // pick the addressed lane out of the raw word
  assign sel_byte = in.raw_data[{in.byte_offset, 3'b000} +: 8];
  assign sel_half = in.byte_offset[1] ? in.raw_data[31:16] : in.raw_data[15:0];

  always_comb begin
    case (in.size)
      lsu_pkg::size_byte: begin
        if (in.is_unsigned) begin
          load_value = {24'd0, sel_byte};
        end else begin
          load_value = {{24{sel_byte[7]}}, sel_byte};
        end
      end
      lsu_pkg::size_half: begin
        if (in.is_unsigned) begin
          load_value = {16'd0, sel_half};
        end else begin
          load_value = {{16{sel_half[15]}}, sel_half};
        end
      end
      default: begin
        load_value = in.raw_data;
      end
    endcase
  end

  always_comb begin
    out.rd   = in.rd;
    out.trap = in.trap;
    if (in.is_load && !in.trap) begin
      out.data = load_value;
      // x0 is never written
      out.write_enable = (in.rd != 5'd0);
    end else begin
      out.data         = 32'd0;
      out.write_enable = 1'b0;
    end
  end

endmodule

// ==== src/lsu_decode.sv ====
`timescale 1ns/1ns

module lsu_decode (
  input  lsu_pkg::instr_packet_t in,
  output lsu_pkg::decoded_t      out
);

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic        legal_load;
  logic        legal_store;

  assign opcode = in.instr[6:0];
  assign funct3 = in.instr[14:12];

  // I-format for loads, S-format splits the immediate around rd
  assign imm_i = {{20{in.instr[31]}}, in.instr[31:20]};
  assign imm_s = {{20{in.instr[31]}}, in.instr[31:25], in.instr[11:7]};

  // LB LH LW LBU LHU use funct3 0,1,2,4,5
  assign legal_load = (opcode == lsu_pkg::opcode_load) &&
                      (funct3 != 3'd3) && (funct3 != 3'd6) && (funct3 != 3'd7);

  // SB SH SW use funct3 0,1,2
  assign legal_store = (opcode == lsu_pkg::opcode_store) && (funct3 <= 3'd2);

  always_comb begin
    out.is_load     = legal_load;
    out.is_store    = legal_store;
    out.is_unsigned = legal_load && funct3[2];
    out.illegal     = !(legal_load || legal_store);
    out.rs1_value   = in.rs1_value;
    out.rs2_value   = in.rs2_value;

    // rd field only means a destination for a load
    if (legal_load) begin
      out.rd = in.instr[11:7];
    end else begin
      out.rd = 5'd0;
    end

    if (legal_store) begin
      out.imm = imm_s;
    end else begin
      out.imm = imm_i;
    end

    case (funct3[1:0])
      2'd0: begin
        out.size = lsu_pkg::size_byte;
      end
      2'd1: begin
        out.size = lsu_pkg::size_half;
      end
      default: begin
        out.size = lsu_pkg::size_word;
      end
    endcase

    // illegal items carry no access at all
    if (out.illegal) begin
      out.size = lsu_pkg::size_word;
    end
  end

endmodule

// ==== src/lsu_execute.sv ====
`timescale 1ns/1ns

module lsu_execute (
  input  lsu_pkg::decoded_t    in,
  output lsu_pkg::access_req_t out
);

  logic [31:0] addr;
  logic        misaligned;

  // effective address is rs1 plus the sign extended immediate
  assign addr = in.rs1_value + in.imm;

  // bytes are never misaligned
  always_comb begin
    case (in.size)
      lsu_pkg::size_word: begin
        misaligned = |addr[1:0];
      end
      lsu_pkg::size_half: begin
        misaligned = addr[0];
      end
      default: begin
        misaligned = 1'b0;
      end
    endcase
  end

  always_comb begin
    out.is_load     = in.is_load;
    out.is_store    = in.is_store;
    out.is_unsigned = in.is_unsigned;
    out.size        = in.size;
    out.rd          = in.rd;
    out.addr        = addr;
    out.store_data  = in.rs2_value;
    out.trap        = in.illegal || misaligned;
  end

endmodule

// ==== src/lsu_pkg.sv ====
package lsu_pkg;

  // RISC-V major opcodes for the load and store classes
  localparam logic [6:0] opcode_load  = 7'b0000011;
  localparam logic [6:0] opcode_store = 7'b0100011;

  // encoded the same way as funct3[1:0]
  typedef enum logic [1:0] {
    size_byte = 2'd0,
    size_half = 2'd1,
    size_word = 2'd2
  } access_size_t;

  // raw instruction with operands already read
  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] rs1_value;
    logic [31:0] rs2_value;
  } instr_packet_t;

  typedef struct packed {
    logic         is_load;
    logic         is_store;
    logic         is_unsigned;
    logic         illegal;
    access_size_t size;
    logic [4:0]   rd;
    logic [31:0]  imm;
    logic [31:0]  rs1_value;
    logic [31:0]  rs2_value;
  } decoded_t;

  // trap covers both illegal encodings and misaligned addresses
  typedef struct packed {
    logic         is_load;
    logic         is_store;
    logic         is_unsigned;
    access_size_t size;
    logic [4:0]   rd;
    logic [31:0]  addr;
    logic [31:0]  store_data;
    logic         trap;
  } access_req_t;

  typedef struct packed {
    logic         is_load;
    logic         is_unsigned;
    access_size_t size;
    logic [4:0]   rd;
    logic [1:0]   byte_offset;
    logic [31:0]  raw_data;
    logic         trap;
  } access_result_t;

  typedef struct packed {
    logic [4:0]  rd;
    logic [31:0] data;
    logic        write_enable;
    logic        trap;
  } writeback_t;

endpackage

// ==== src/lsu_top.sv ====
`timescale 1ns/1ns

module lsu_top #(
  parameter int ram_words = 256
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   in_valid,
  output logic                   in_ready,
  input  lsu_pkg::instr_packet_t in,
  output logic                   out_valid,
  input  logic                   out_ready,
  output lsu_pkg::writeback_t    out
);

  lsu_pkg::decoded_t              dec_comb;
  lsu_pkg::decoded_t              dec_q;
  logic                           dec_valid;
  logic                           dec_ready;
  lsu_pkg::access_req_t           req_comb;
  lsu_pkg::access_req_t           req_q;
  logic                           req_valid;
  logic                           req_ready;
  lsu_pkg::access_result_t        res;
  logic                           res_valid;
  logic                           res_ready;
  lsu_pkg::writeback_t            wb_comb;
  logic                           mem_valid;
  logic                           mem_ready;
  logic [$clog2(ram_words)-1:0]   mem_addr;
  logic [3:0]                     mem_wstrb;
  logic [31:0]                    mem_wdata;
  logic [31:0]                    mem_rdata;

  lsu_decode lsu_decode_inst (.in(in), .out(dec_comb));

  stage_reg #(.payload_t(lsu_pkg::decoded_t)) decode_reg (
    .clk(clk), .reset(reset),
    .in_valid(in_valid), .in_ready(in_ready), .in_data(dec_comb),
    .out_valid(dec_valid), .out_ready(dec_ready), .out_data(dec_q)
  );

  lsu_execute lsu_execute_inst (.in(dec_q), .out(req_comb));

  stage_reg #(.payload_t(lsu_pkg::access_req_t)) execute_reg (
    .clk(clk), .reset(reset),
    .in_valid(dec_valid), .in_ready(dec_ready), .in_data(req_comb),
    .out_valid(req_valid), .out_ready(req_ready), .out_data(req_q)
  );

  accessor #(.ram_words(ram_words)) accessor_inst (
    .clk(clk), .reset(reset),
    .req_valid(req_valid), .req_ready(req_ready), .req(req_q),
    .result_valid(res_valid), .result_ready(res_ready), .result(res),
    .mem_valid(mem_valid), .mem_ready(mem_ready), .mem_addr(mem_addr),
    .mem_wstrb(mem_wstrb), .mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
  );

  load_align load_align_inst (.in(res), .out(wb_comb));

  stage_reg #(.payload_t(lsu_pkg::writeback_t)) writeback_reg (
    .clk(clk), .reset(reset),
    .in_valid(res_valid), .in_ready(res_ready), .in_data(wb_comb),
    .out_valid(out_valid), .out_ready(out_ready), .out_data(out)
  );

  data_ram #(.ram_words(ram_words)) data_ram_inst (
    .clk(clk), .reset(reset),
    .mem_valid(mem_valid), .mem_ready(mem_ready), .mem_addr(mem_addr),
    .mem_wstrb(mem_wstrb), .mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
  );

endmodule

// ==== src/stage_reg.sv ====
`timescale 1ns/1ns

module stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  logic full;

  // loads when empty or when the held item leaves this cycle
  assign in_ready  = !full || out_ready;
  assign out_valid = full;

  always_ff @(posedge clk) begin
    if (reset) begin
      full <= 1'b0;
    end else if (in_ready) begin
      full <= in_valid;
    end
  end

  // payload only changes on a transfer
  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      out_data <= in_data;
    end
  end

endmodule

// ==== include/lsu_tb_model.svh ====
`ifndef LSU_TB_MODEL_SVH
`define LSU_TB_MODEL_SVH

// model memory matches the RAM depth used by the testbench
localparam int model_words = 256;
logic [31:0] model_mem [model_words];

function automatic void model_clear();
  for (int i = 0; i < model_words; i++) begin
    model_mem[i] = 32'd0;
  end
endfunction

// applies one instruction to the model and returns its expected writeback
function automatic lsu_pkg::writeback_t model_step(lsu_pkg::instr_packet_t p);
  lsu_pkg::writeback_t wb;
  logic [2:0]  funct3;
  logic [31:0] imm;
  logic [31:0] addr;
  logic [31:0] word;
  logic        legal_load;
  logic        legal_store;
  int          idx;
  funct3      = p.instr[14:12];
  legal_load  = (p.instr[6:0] == lsu_pkg::opcode_load) && !(funct3 inside {3, 6, 7});
  legal_store = (p.instr[6:0] == lsu_pkg::opcode_store) && (funct3 <= 3'd2);
  imm = legal_store ? {{20{p.instr[31]}}, p.instr[31:25], p.instr[11:7]}
                    : {{20{p.instr[31]}}, p.instr[31:20]};
  addr = p.rs1_value + imm;
  idx  = (addr >> 2) % model_words;
  word = model_mem[idx] >> (addr[1:0] * 8);
  wb = '0;
  wb.rd = legal_load ? p.instr[11:7] : 5'd0;
  wb.trap = !(legal_load || legal_store) || ((funct3[1:0] == 2'd2) && (addr[1:0] != 2'd0)) ||
            ((funct3[1:0] == 2'd1) && addr[0]);
  if (wb.trap) return wb;
  if (legal_store) begin
    case (funct3[1:0])
      2'd0: model_mem[idx][addr[1:0]*8 +: 8] = p.rs2_value[7:0];
      2'd1: model_mem[idx][addr[1:0]*8 +: 16] = p.rs2_value[15:0];
      default: model_mem[idx] = p.rs2_value;
    endcase
    return wb;
  end
  case (funct3)
    3'd0: wb.data = {{24{word[7]}}, word[7:0]};
    3'd1: wb.data = {{16{word[15]}}, word[15:0]};
    3'd4: wb.data = {24'd0, word[7:0]};
    3'd5: wb.data = {16'd0, word[15:0]};
    default: wb.data = word;
  endcase
  wb.write_enable = (wb.rd != 5'd0);
  return wb;
endfunction

`endif

// ==== testbench/lsu_tb.sv ====
`timescale 1ns/1ns

module lsu_tb;

  localparam int directed_items = 23;
  localparam int random_items   = 60;
  localparam int long_items     = 300;

  logic                   clk;
  logic                   reset;
  logic                   in_valid;
  logic                   in_ready;
  lsu_pkg::instr_packet_t in_pkt;
  logic                   out_valid;
  logic                   out_ready;
  lsu_pkg::writeback_t    out_wb;

  integer              stim_seed;
  integer              ready_seed;
  int                  low_percent;
  int                  received;
  lsu_pkg::writeback_t expected[$];

  `include "lsu_tb_model.svh"

  lsu_top #(.ram_words(256)) lsu_top_inst (
    .clk(clk), .reset(reset), .in_valid(in_valid), .in_ready(in_ready), .in(in_pkt),
    .out_valid(out_valid), .out_ready(out_ready), .out(out_wb)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    if (exp_v !== act_v) begin
      $display("** Error: %s expected %h actual %h", name, exp_v, act_v);
      $display("TEST RESULT: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // holds the item until in_ready is seen mid cycle, the model steps on acceptance
  task automatic send_item(input lsu_pkg::instr_packet_t p);
    logic took;
    in_valid = 1'b1;
    in_pkt   = p;
    took     = 1'b0;
    while (!took) begin
      @(negedge clk);
      took = in_ready;
      if (took) begin
        expected.push_back(model_step(p));
      end
      @(posedge clk);
      #1;
    end
    in_valid = 1'b0;
  endtask

  // the address is split into rs1 plus a random 12 bit immediate
  task automatic send_access(input logic is_store, input logic [2:0] funct3,
                             input logic [4:0] rd, input logic [31:0] addr,
                             input logic [31:0] rs2);
    logic [31:0] r;
    logic [31:0] instr;
    r = $random(stim_seed);
    if (is_store) begin
      instr = {r[11:5], 5'd2, 5'd1, funct3, r[4:0], lsu_pkg::opcode_store};
    end else begin
      instr = {r[11:0], 5'd1, funct3, rd, lsu_pkg::opcode_load};
    end
    send_item({instr, addr - {{20{r[11]}}, r[11:0]}, rs2});
  endtask

  task automatic send_raw(input logic [31:0] instr);
    logic [31:0] rs1;
    logic [31:0] rs2;
    rs1 = $random(stim_seed);
    rs2 = $random(stim_seed);
    send_item({instr, rs1, rs2});
  endtask

  task automatic random_item();
    logic [31:0] r;
    logic [31:0] s;
    logic [31:0] d;
    logic [2:0]  funct3;
    logic [1:0]  off;
    int          kind;
    r    = $random(stim_seed);
    s    = $random(stim_seed);
    d    = $random(stim_seed);
    kind = $unsigned(r) % 100;
    if (kind < 3) begin
      // an R-type word is outside the load/store classes
      send_raw({d[31:7], 7'b0110011});
    end else if (kind < 6) begin
      funct3 = s[9] ? 3'd3 : {2'b11, s[10]};
      if (s[8]) begin
        funct3 = {1'b1, s[10:9]};
      end
      send_access(s[8], funct3, s[4:0], {22'd0, s[12:8], 5'd0}, d);
    end else begin
      funct3 = {(kind >= 50) && s[7], s[6:5]};
      if (funct3[1:0] == 2'd3) begin
        funct3[1:0] = 2'd0;
      end
      if (funct3 == 3'd6) begin
        funct3 = 3'd4;
      end
      case (funct3[1:0])
        2'd0: off = s[14:13];
        2'd1: off = {s[14], 1'b0};
        default: off = 2'b00;
      endcase
      // a few misaligned tries, and a few addresses that wrap the RAM
      off = (s[17:15] == 3'd0) ? s[14:13] : off;
      send_access(kind < 50, funct3, s[4:0],
                  {(s[21:18] == 4'd0) ? {s[31:22], 12'd0} : 22'd0, 3'd0, s[12:8], off}, d);
    end
  endtask

  task automatic wait_drain();
    while (expected.size() != 0) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic take_result();
    lsu_pkg::writeback_t exp_wb;
    if (expected.size() == 0) begin
      $display("a result came out with no instruction outstanding");
      $display("TEST RESULT: FAIL");
      $fatal(1, "unexpected result");
    end else begin
      exp_wb = expected.pop_front();
      check_value($sformatf("item %0d rd", received), 32'(exp_wb.rd), 32'(out_wb.rd));
      check_value($sformatf("item %0d data", received), exp_wb.data, out_wb.data);
      check_value($sformatf("item %0d write_enable", received),
                  32'(exp_wb.write_enable), 32'(out_wb.write_enable));
      check_value($sformatf("item %0d trap", received), 32'(exp_wb.trap), 32'(out_wb.trap));
      received++;
    end
  endtask

  // output side, back-pressure drawn from its own random stream
  initial begin
    out_ready = 1'b1;
    forever begin
      @(posedge clk);
      #1;
      out_ready = ($unsigned($random(ready_seed)) % 100) >= low_percent;
      @(negedge clk);
      if (out_valid && out_ready) begin
        take_result();
      end
    end
  end

  initial begin
    stim_seed   = 32'h75cd;
    ready_seed  = ~32'h75cd;
    low_percent = 0;
    received    = 0;
    reset       = 1'b1;
    in_valid    = 1'b0;
    in_pkt      = '0;
    model_clear();
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;
    repeat (4) begin
      @(negedge clk);
      check_value("idle out_valid", 32'd0, 32'(out_valid));
      check_value("idle in_ready", 32'd1, 32'(in_ready));
    end
    @(posedge clk);
    #1;
    // stores of each size, then loads over the merged lanes
    send_access(1'b1, 3'd2, 5'd0, 32'h10, 32'h11223344);
    send_access(1'b1, 3'd2, 5'd0, 32'h14, 32'h8899aabb);
    send_access(1'b1, 3'd1, 5'd0, 32'h16, 32'h0000fedc);
    send_access(1'b1, 3'd0, 5'd0, 32'h11, 32'h00000080);
    send_access(1'b0, 3'd2, 5'd5, 32'h10, 32'd0);
    send_access(1'b0, 3'd0, 5'd6, 32'h11, 32'd0);
    send_access(1'b0, 3'd4, 5'd7, 32'h11, 32'd0);
    send_access(1'b0, 3'd1, 5'd8, 32'h16, 32'd0);
    send_access(1'b0, 3'd5, 5'd9, 32'h16, 32'd0);
    send_access(1'b0, 3'd1, 5'd10, 32'h12, 32'd0);
    send_access(1'b1, 3'd0, 5'd0, 32'h17, 32'h0000007f);
    send_access(1'b0, 3'd0, 5'd11, 32'h17, 32'd0);
    send_access(1'b0, 3'd4, 5'd12, 32'h14, 32'd0);
    // misaligned and illegal items must not touch memory
    send_access(1'b0, 3'd2, 5'd13, 32'h12, 32'd0);
    send_access(1'b0, 3'd1, 5'd14, 32'h15, 32'd0);
    send_access(1'b1, 3'd2, 5'd0, 32'h11, 32'hdeadbeef);
    send_access(1'b1, 3'd1, 5'd0, 32'h13, 32'h0000beef);
    send_access(1'b0, 3'd3, 5'd15, 32'h10, 32'd0);
    send_access(1'b1, 3'd5, 5'd0, 32'h10, 32'hffffffff);
    send_raw(32'h00a00093);
    send_access(1'b0, 3'd2, 5'd16, 32'h10, 32'd0);
    send_access(1'b0, 3'd2, 5'd17, 32'h14, 32'd0);
    send_access(1'b0, 3'd2, 5'd0, 32'h14, 32'd0);
    wait_drain();
    low_percent = 40;
    repeat (random_items) random_item();
    wait_drain();
    // long mixed run keeps several items in flight
    low_percent = 10;
    repeat (long_items) begin
      random_item();
      if ($unsigned($random(stim_seed)) % 8 == 0) begin
        @(posedge clk);
        #1;
      end
    end
    wait_drain();
    repeat (10) @(posedge clk);
    @(negedge clk);
    // every stage must be empty once all results have been taken
    if (!out_valid && in_ready) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      $display("pipeline still holds an item after %0d results", received);
      $display("TEST RESULT: FAIL");
      $fatal(1, "pipeline not empty");
    end
  end

  // about 40 ns per item plus reset and drain time
  initial begin
    #((directed_items + random_items + long_items) * 40 + 2000);
    $display("watchdog expired before every result arrived");
    $display("TEST RESULT: FAIL");
    $fatal(1, "timeout");
  end

endmodule

// ==== vlog.f ====
+incdir+include
src/lsu_pkg.sv
src/stage_reg.sv
src/lsu_decode.sv
src/lsu_execute.sv
src/accessor.sv
src/load_align.sv
src/data_ram.sv
src/lsu_top.sv
testbench/lsu_tb.sv
